// ==== verilog/nnLayer_config.svh ====
`ifndef NN_LAYER_CONFIG_SVH
`define NN_LAYER_CONFIG_SVH

// Layer geometry.
`define NN_INPUTS 15 // Activations seen by every neuron.
`define NN_NEURONS 4

// Activations and weights carry this many fraction bits.
`define NN_FRAC 6

// Configuration address fields.
`define NN_SLOT_BITS 4 // Slots 0 to 7 hold weight pairs, slot 8 the bias.
`define NN_IDX_BITS 2

`endif

// ==== verilog/nnDataPkg.sv ====
package nnDataPkg;

	// Activations are fractional with six fraction bits.
	typedef logic signed [7:0] activation_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;

	// One activation times one weight always fits in sixteen bits.
	typedef logic signed [15:0] product_t;

	// Fifteen products plus the bias, with room to spare.
	typedef logic signed [22:0] accum_t;

	typedef logic [7:0] layerOut_t; // Rectifier result, 0 to 127.

endpackage

// ==== verilog/nnCfgPkg.sv ====
`include "nnLayer_config.svh"

package nnCfgPkg;

	// Low byte weights the even input, high byte the odd one.
	typedef struct packed {
		nnDataPkg::weight_t odd;
		nnDataPkg::weight_t even;
	} weightPair_t;

	// One configuration word, read as a weight pair or as a bias depending on the slot.
	typedef union packed {
		weightPair_t pair;
		nnDataPkg::bias_t bias;
	} cfgWord_t;

	// Slot k holds the weights of inputs 2k and 2k+1.
	localparam logic [`NN_SLOT_BITS-1:0] SLOT_LAST_PAIR = 7;
	localparam logic [`NN_SLOT_BITS-1:0] SLOT_BIAS = 8;

endpackage

// ==== verilog/layerWeightStore.sv ====
`timescale 1ns/1ps
`include "nnLayer_config.svh"

module layerWeightStore
(
	input logic clk,
	input logic reset,
	input logic cfgWrite,
	input logic [`NN_IDX_BITS-1:0] cfgNeuron,
	input logic [`NN_SLOT_BITS-1:0] cfgSlot,
	input nnCfgPkg::cfgWord_t cfgData,
	output nnDataPkg::weight_t [`NN_INPUTS-1:0] weights [`NN_NEURONS],
	output nnDataPkg::bias_t biases [`NN_NEURONS]
);
	import nnCfgPkg::*;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < `NN_NEURONS; n++)
			begin
				weights[n] <= '0;
				biases[n] <= '0;
			end
		end
		else if (cfgWrite)
		begin
			if (cfgSlot == SLOT_BIAS)
				biases[cfgNeuron] <= cfgData.bias;
			else if (cfgSlot <= SLOT_LAST_PAIR)
			begin
				// The odd byte of the last slot has no input behind it and is dropped here.
				for (int i = 0; i < `NN_INPUTS; i++)
				begin
					if ((i >> 1) == int'(cfgSlot))
						weights[cfgNeuron][i] <= i[0] ? cfgData.pair.odd : cfgData.pair.even;
				end
			end
		end
	end

	// Slots above the bias slot do not exist.
	assert property (@(posedge clk) disable iff (reset) cfgWrite |-> cfgSlot <= SLOT_BIAS)
		else $error("configuration write to undefined slot %0d", cfgSlot);

endmodule

// ==== verilog/neuronNode.sv ====
`timescale 1ns/1ps
`include "nnLayer_config.svh"

module neuronNode
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnDataPkg::activation_t [`NN_INPUTS-1:0] inAct,
	input nnDataPkg::weight_t [`NN_INPUTS-1:0] weights,
	input nnDataPkg::bias_t bias,
	output nnDataPkg::layerOut_t nodeOut,
	output logic nodeValid
);
	import nnDataPkg::*;

	activation_t [`NN_INPUTS-1:0] actReg;
	logic actValid;
	accum_t sumNext;
	accum_t sumReg;
	logic sumValid;
	logic [8:0] rounded;
	layerOut_t rectified;

	// Stage 1. Capture the activations of a new vector.
	always_ff @(posedge clk)
	begin
		if (inValid)
			actReg <= inAct;
	end

	// Weighted sum, every product sign extended before it is added.
	always_comb
	begin
		sumNext = accum_t'(bias);
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			sumNext = sumNext
				+ accum_t'(product_t'($signed(actReg[i])) * product_t'($signed(weights[i])));
		end
	end

	// Stage 2. The weights are sampled here, so a write counts from the next sum on.
	always_ff @(posedge clk)
	begin
		if (actValid)
			sumReg <= sumNext;
	end

	// Drop the fraction bits and round half up on the first dropped bit.
	assign rounded = {1'b0, sumReg[`NN_FRAC+7:`NN_FRAC]} + 9'(sumReg[`NN_FRAC-1]);

	always_comb
	begin
		if (sumReg[$bits(accum_t)-1])
			rectified = '0; // Negative sums are cut off.
		else if (sumReg[$bits(accum_t)-1:`NN_FRAC+7] != '0)
			rectified = 8'd127;
		else if (rounded > 9'd127)
			rectified = 8'd127; // Rounding can carry past the top.
		else
			rectified = rounded[7:0];
	end

	// Stage 3 and the valid pipeline that follows the data.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actValid <= 1'b0;
			sumValid <= 1'b0;
			nodeValid <= 1'b0;
			nodeOut <= '0;
		end
		else
		begin
			actValid <= inValid;
			sumValid <= actValid;
			nodeValid <= sumValid;
			if (sumValid)
				nodeOut <= rectified;
		end
	end

	// A result only ever comes out of a vector that went in three cycles before.
	assert property (@(posedge clk) disable iff (reset) $rose(nodeValid) |-> $past(inValid, 3))
		else $error("nodeValid rose without inValid three cycles earlier");

endmodule

// ==== verilog/layerOutputCollector.sv ====
`timescale 1ns/1ps
`include "nnLayer_config.svh"

module layerOutputCollector
(
	input logic clk,
	input logic reset,
	input logic nodeValid,
	input nnDataPkg::layerOut_t [`NN_NEURONS-1:0] nodeOuts,
	output nnDataPkg::layerOut_t [`NN_NEURONS-1:0] layerOut,
	output logic [`NN_IDX_BITS-1:0] winner,
	output logic outValid
);
	import nnDataPkg::*;

	layerOut_t bestValue;
	logic [`NN_IDX_BITS-1:0] bestIndex;

	// Linear scan for the largest output.
	always_comb
	begin
		bestValue = nodeOuts[0];
		bestIndex = '0;
		for (int i = 1; i < `NN_NEURONS; i++)
		begin
			if (nodeOuts[i] > bestValue) // Strict, so a tie keeps the lower index.
			begin
				bestValue = nodeOuts[i];
				bestIndex = i[`NN_IDX_BITS-1:0];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			layerOut <= '0;
			winner <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			outValid <= nodeValid;
			if (nodeValid)
			begin
				layerOut <= nodeOuts;
				winner <= bestIndex;
			end
		end
	end

endmodule

// ==== verilog/neuronLayer.sv ====
`timescale 1ns/1ps
`include "nnLayer_config.svh"

module neuronLayer
(
	input logic clk,
	input logic reset,
	input logic cfgWrite,
	input logic [`NN_IDX_BITS-1:0] cfgNeuron,
	input logic [`NN_SLOT_BITS-1:0] cfgSlot,
	input nnCfgPkg::cfgWord_t cfgData,
	input logic inValid,
	input nnDataPkg::activation_t [`NN_INPUTS-1:0] inAct,
	output nnDataPkg::layerOut_t [`NN_NEURONS-1:0] layerOut,
	output logic [`NN_IDX_BITS-1:0] winner,
	output logic outValid
);
	import nnDataPkg::*;

	weight_t [`NN_INPUTS-1:0] weights [`NN_NEURONS];
	bias_t biases [`NN_NEURONS];
	layerOut_t [`NN_NEURONS-1:0] nodeOuts;
	logic [`NN_NEURONS-1:0] nodeValid;

	layerWeightStore i_layerWeightStore
	(
		.clk(clk),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgNeuron(cfgNeuron),
		.cfgSlot(cfgSlot),
		.cfgData(cfgData),
		.weights(weights),
		.biases(biases)
	);

	for (genvar g = 0; g < `NN_NEURONS; g++)
	begin : gNeuron
		neuronNode i_neuronNode
		(
			.clk(clk),
			.reset(reset),
			.inValid(inValid),
			.inAct(inAct),
			.weights(weights[g]),
			.bias(biases[g]),
			.nodeOut(nodeOuts[g]),
			.nodeValid(nodeValid[g])
		);
	end

	// All neurons share one input strobe, so neuron 0 speaks for the layer.
	layerOutputCollector i_layerOutputCollector
	(
		.clk(clk),
		.reset(reset),
		.nodeValid(nodeValid[0]),
		.nodeOuts(nodeOuts),
		.layerOut(layerOut),
		.winner(winner),
		.outValid(outValid)
	);

endmodule

// ==== bench/neuronLayerTb.sv ====
`timescale 1ns/1ps
`include "nnLayer_config.svh"

module neuronLayerTb;
	import nnDataPkg::*;
	import nnCfgPkg::*;

	localparam int LATENCY = 4;
	localparam int DRAIN_LIMIT = 50; // Cycles allowed for the last results to come out.

	logic clk;
	logic reset;
	logic cfgWrite;
	logic [`NN_IDX_BITS-1:0] cfgNeuron;
	logic [`NN_SLOT_BITS-1:0] cfgSlot;
	cfgWord_t cfgData;
	logic inValid;
	activation_t [`NN_INPUTS-1:0] inAct;
	layerOut_t [`NN_NEURONS-1:0] layerOut;
	logic [`NN_IDX_BITS-1:0] winner;
	logic outValid;

	// Expected results in the order the vectors went in.
	layerOut_t [`NN_NEURONS-1:0] expOuts [$];
	logic [`NN_IDX_BITS-1:0] expWinners [$];
	int expCycles [$];

	int cycle = 0;
	int vectors = 0;
	int checks = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	int runErrors = 0;

	neuronLayer i_neuronLayer
	(
		.clk(clk),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgNeuron(cfgNeuron),
		.cfgSlot(cfgSlot),
		.cfgData(cfgData),
		.inValid(inValid),
		.inAct(inAct),
		.layerOut(layerOut),
		.winner(winner),
		.outValid(outValid)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic checkResult();
		layerOut_t [`NN_NEURONS-1:0] wantOuts;
		logic [`NN_IDX_BITS-1:0] wantWinner;
		int sentCycle;
		if (expOuts.size() == 0)
		begin
			$display("outValid went high at cycle %0d with no vector outstanding", cycle);
			otherErrors++;
			return;
		end
		wantOuts = expOuts.pop_front();
		wantWinner = expWinners.pop_front();
		sentCycle = expCycles.pop_front();
		checks++;
		if (cycle - sentCycle != LATENCY)
		begin
			$display("result came %0d cycles after its vector instead of %0d",
				cycle - sentCycle, LATENCY);
			otherErrors++;
		end
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			if (layerOut[n] !== wantOuts[n])
			begin
				$display("ERROR layerOut[%0d] got %h expected %h", n, layerOut[n], wantOuts[n]);
				valueErrors++;
			end
		end
		if (winner !== wantWinner)
		begin
			$display("ERROR winner got %h expected %h", winner, wantWinner);
			valueErrors++;
		end
	endtask

	// Outputs are registered, so the falling edge sees them settled.
	always @(negedge clk)
	begin
		if (outValid)
			checkResult();
	end

	task automatic readHex(input int fd, output logic [31:0] value);
		int code;
		logic [31:0] field;
		field = '0;
		code = $fscanf(fd, " %h", field);
		if (code != 1)
		begin
			$display("the stimulus file ended in the middle of a line");
			runErrors++;
		end
		value = field;
	endtask

	task automatic driveWrite(input int fd);
		logic [31:0] field;
		readHex(fd, field);
		cfgNeuron = field[`NN_IDX_BITS-1:0];
		readHex(fd, field);
		cfgSlot = field[`NN_SLOT_BITS-1:0];
		readHex(fd, field);
		cfgData = field[15:0];
		cfgWrite = 1'b1;
	endtask

	task automatic driveVector(input int fd);
		logic [31:0] field;
		layerOut_t [`NN_NEURONS-1:0] wantOuts;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			readHex(fd, field);
			inAct[i] = field[7:0];
		end
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			readHex(fd, field);
			wantOuts[n] = field[7:0];
		end
		readHex(fd, field);
		expOuts.push_back(wantOuts);
		expWinners.push_back(field[`NN_IDX_BITS-1:0]);
		expCycles.push_back(cycle);
		inValid = 1'b1;
		vectors++;
	endtask

	initial
	begin
		int fd;
		int code;
		int waited;
		logic [7:0] kind;
		logic [8*128-1:0] skipLine;
		reset = 1'b1;
		cfgWrite = 1'b0;
		cfgNeuron = '0;
		cfgSlot = '0;
		cfgData = '0;
		inValid = 1'b0;
		inAct = '0;
		fd = $fopen("bench/layerStim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open bench/layerStim.txt");
			$display("TESTBENCH FAILED");
			$finish;
		end
		else
		begin
			repeat (10) @(posedge clk);
			#1;
			reset = 1'b0;
			// One line of the file per clock cycle, so vectors run back to back.
			code = $fscanf(fd, " %c", kind);
			while (code == 1)
			begin
				if (kind == "#")
					code = $fgets(skipLine, fd);
				else
				begin
					@(posedge clk);
					#1;
					cfgWrite = 1'b0;
					inValid = 1'b0;
					if (kind == "W")
						driveWrite(fd);
					else if (kind == "V")
						driveVector(fd);
					else
					begin
						$display("unknown line kind %c in the stimulus file", kind);
						runErrors++;
						code = $fgets(skipLine, fd);
					end
				end
				code = $fscanf(fd, " %c", kind);
			end
			$fclose(fd);
			@(posedge clk);
			#1;
			cfgWrite = 1'b0;
			inValid = 1'b0;
			waited = 0;
			while (expOuts.size() != 0 && waited < DRAIN_LIMIT)
			begin
				@(posedge clk);
				waited++;
			end
			if (expOuts.size() != 0)
			begin
				$display("timed out with %0d results never delivered", expOuts.size());
				runErrors++;
			end
			if (vectors == 0)
			begin
				$display("the stimulus file held no vectors");
				runErrors++;
			end
			$display("vectors %0d, checked %0d, value errors %0d, other errors %0d",
				vectors, checks, valueErrors, otherErrors + runErrors);
			if (valueErrors == 0 && otherErrors == 0 && runErrors == 0 && checks == vectors)
				$display("TESTBENCH PASSED");
			else
				$display("TESTBENCH FAILED");
			$finish;
		end
	end

endmodule

// ==== bench/layerStim.txt ====
# W neuron slot data : configuration write, all fields hex.
# V act0..act14 out0..out3 winner : vector and expected layer outputs, all hex.
# Nothing configured yet, so every neuron answers zero.
V 40 C0 7F 80 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0
# Weight pairs for four different neurons; the high byte of slot 7 has no input.
W 1 0 2040
W 2 7 7F30
W 3 3 F010
W 0 1 0021
# One nonzero input per vector, back to back.
V 40 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 40 00 00 1
V 00 40 00 00 00 00 00 00 00 00 00 00 00 00 00 00 20 00 00 1
V 00 00 00 00 00 00 00 00 00 00 00 00 00 00 20 00 00 18 00 2
V 00 00 00 00 00 00 40 00 00 00 00 00 00 00 00 00 00 00 10 3
V 00 00 00 00 00 00 00 40 00 00 00 00 00 00 00 00 00 00 00 0
V 00 00 01 00 00 00 00 00 00 00 00 00 00 00 00 01 00 00 00 0
V 00 00 03 00 00 00 00 00 00 00 00 00 00 00 00 02 00 00 00 0
# Bias on neuron 1 pushes the sum past the saturation limit.
W 1 8 1000
V 7F 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7F 00 00 1
V 80 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0
# Neurons 1 and 2 tie, the lower index wins.
V 00 00 00 00 00 00 00 00 00 00 00 00 00 00 55 00 40 40 00 1
# Several inputs at once.
V 10 00 40 00 00 00 7F 20 00 00 00 00 00 00 08 21 50 06 18 1
# All weights cleared, only the biases remain.
W 0 1 0000
W 0 8 FF00
W 1 0 0000
W 2 7 0000
W 2 8 00A0
W 3 3 0000
W 3 8 0C30
V 7F 80 40 C0 11 22 33 44 55 66 77 88 99 AA BB 00 40 03 31 1
V 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 00 40 03 31 1

// ==== list.f ====
+incdir+verilog
verilog/nnDataPkg.sv
verilog/nnCfgPkg.sv
verilog/layerWeightStore.sv
verilog/neuronNode.sv
verilog/layerOutputCollector.sv
verilog/neuronLayer.sv
bench/neuronLayerTb.sv

// ==== Makefile ====
# Verilator build and run of the neuron layer testbench.

VERILATOR ?= verilator
TOP ?= neuronLayerTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
